/* source/agu_settings.svh */
`ifndef AGU_SETTINGS_SVH
`define AGU_SETTINGS_SVH

// virtual and physical address widths
`define AGU_VADDR_W 48
`define AGU_PADDR_W 44

// 8 KiB pages
`define AGU_PAGE_W 13

// data cache has 32 banks of four bytes each
`define AGU_BANKS 32

// fully associative data TLB
`define AGU_TLB_ENTRIES 8

// store queue tag
`define AGU_TAG_W 9

`endif

/* source/agu_pkg.sv */
package agu_pkg;

  `include "agu_settings.svh"

  localparam int VPN_W  = `AGU_VADDR_W - `AGU_PAGE_W;
  localparam int PPN_W  = `AGU_PADDR_W - `AGU_PAGE_W;
  localparam int BANK_W = $clog2(`AGU_BANKS);

  // store opcodes, size is 1 << encoding
  typedef enum logic [2:0] {
    op_st_b = 3'd0,
    op_st_h = 3'd1,
    op_st_w = 3'd2,
    op_st_d = 3'd3,
    op_st_q = 3'd4
  } store_op_e;

  // request, address already summed
  typedef struct packed {
    store_op_e              op;
    logic [`AGU_VADDR_W-1:0] vaddr;
    logic                   kernel;
    logic [`AGU_TAG_W-1:0]   tag;
  } agu_req_t;

  typedef struct packed {
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] ppn;
    logic             present;
    logic             write_protect;
    logic             system;
  } tlb_entry_t;

  // fault[0] protection, fault[1] privilege
  typedef struct packed {
    logic             hit;
    logic [PPN_W-1:0] ppn;
    logic [1:0]       fault;
  } tlb_look_t;

  typedef struct packed {
    logic [`AGU_PADDR_W-1:0] paddr;
    // ppn of the page after paddr
    logic [PPN_W-1:0]       paddr_next;
    logic [`AGU_BANKS-1:0]   banks;
    logic [BANK_W-1:0]      first_bank;
    logic [4:0]             size;
    logic                   split;
    logic                   cross_page;
    logic [`AGU_TAG_W-1:0]   tag;
  } mem_op_t;

  // code[0] protection, code[1] privilege, code[2] illegal opcode
  typedef struct packed {
    logic [2:0]           code;
    logic [`AGU_TAG_W-1:0] tag;
  } fault_t;

endpackage

/* source/agu_op_decode.sv */
`timescale 1ns/1ps

module agu_op_decode import agu_pkg::*; (
  input  store_op_e  op,
  output logic [4:0] bytes,
  output logic       illegal
);

  // size decode straight off the enum
  always_comb begin
    illegal = 1'b0;
    case (op)
      op_st_b: begin
        bytes = 5'd1;
      end
      op_st_h: begin
        bytes = 5'd2;
      end
      op_st_w: begin
        bytes = 5'd4;
      end
      op_st_d: begin
        bytes = 5'd8;
      end
      op_st_q: begin
        bytes = 5'd16;
      end
      default: begin
        // treat as a single byte so the bank map stays sane
        bytes   = 5'd1;
        illegal = 1'b1;
      end
    endcase
  end

endmodule

/* source/agu_bank_map.sv */
`timescale 1ns/1ps
`include "agu_settings.svh"

module agu_bank_map import agu_pkg::*; (
  input  logic [`AGU_PAGE_W-1:0] vaddr_low,
  input  logic [4:0]            bytes,
  output logic [`AGU_BANKS-1:0]  banks,
  output logic [BANK_W-1:0]     first_bank,
  output logic                  split,
  output logic                  cross_page
);

  localparam int OFF_W = `AGU_PAGE_W + 1;
  localparam logic [OFF_W-1:0] PAGE_BYTES = OFF_W'(1) << `AGU_PAGE_W;

  // at most 3 + 16 + 3, fits in five bits
  logic [4:0]              span_sum;
  logic [2:0]              count;
  logic [`AGU_BANKS-1:0]    run;
  logic [2*`AGU_BANKS-1:0]  wide;
  logic [BANK_W+1:0]       last_bank;
  logic [OFF_W-1:0]        end_off;

  assign first_bank = vaddr_low[BANK_W+1:2];

  always_comb begin
    // number of 4-byte banks touched
    span_sum = 5'(vaddr_low[1:0]) + bytes + 5'd3;
    count    = span_sum[4:2];

    // run of ones, rotated left to start at first_bank
    run   = (`AGU_BANKS'(1) << count) - `AGU_BANKS'(1);
    wide  = {{`AGU_BANKS{1'b0}}, run} << first_bank;
    banks = wide[`AGU_BANKS-1:0] | wide[2*`AGU_BANKS-1:`AGU_BANKS];

    // range runs past bank 31
    last_bank = (BANK_W + 2)'(first_bank) + (BANK_W + 2)'(count);
    split     = last_bank > (BANK_W + 2)'(`AGU_BANKS);

    // last byte lands in the next page
    end_off    = OFF_W'(vaddr_low) + OFF_W'(bytes);
    cross_page = end_off > PAGE_BYTES;
  end

endmodule

/* source/agu_dtlb.sv */
`timescale 1ns/1ps
`include "agu_settings.svh"

module agu_dtlb import agu_pkg::*; #(
  parameter int ENTRIES = `AGU_TLB_ENTRIES,
  parameter int IDX_W   = $clog2(`AGU_TLB_ENTRIES)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr,
  input  logic [IDX_W-1:0] wr_index,
  input  tlb_entry_t       wr_entry,
  input  logic [VPN_W-1:0] vpn,
  input  logic             kernel,
  output tlb_look_t        look,
  output tlb_look_t        look_next
);

  tlb_entry_t         entries_q [ENTRIES];
  logic [ENTRIES-1:0] valid_q;
  logic [VPN_W-1:0]   vpn_next;

  // entry storage, filled through the write port
  always_ff @(posedge clk) begin
    if (wr) begin
      entries_q[wr_index] <= wr_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr) begin
      valid_q[wr_index] <= 1'b1;
    end
  end

  // one associative search over all entries
  function automatic tlb_look_t search(input logic [VPN_W-1:0] key);
    tlb_look_t res;
    res = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (valid_q[i] && entries_q[i].vpn == key) begin
        res.hit      = 1'b1;
        res.ppn      = entries_q[i].ppn;
        // not present or write protected
        res.fault[0] = ~entries_q[i].present | entries_q[i].write_protect;
        // system page from user mode
        res.fault[1] = entries_q[i].system & ~kernel;
      end
    end
    return res;
  endfunction

  // the following page, for stores that cross a page
  assign vpn_next = vpn + VPN_W'(1);

  always_comb begin
    look      = search(vpn);
    look_next = search(vpn_next);
  end

endmodule

/* source/agu_result.sv */
`timescale 1ns/1ps
`include "agu_settings.svh"

module agu_result import agu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cancel,
  input  logic                  s1_valid,
  input  agu_req_t              s1_req,
  input  logic                  s1_illegal,
  input  logic [4:0]            s1_bytes,
  input  logic [`AGU_BANKS-1:0]  s1_banks,
  input  logic [BANK_W-1:0]     s1_first_bank,
  input  logic                  s1_split,
  input  logic                  s1_cross_page,
  input  tlb_look_t             s1_look,
  input  tlb_look_t             s1_look_next,
  output logic                  mop_valid,
  output mem_op_t               mop,
  output logic                  miss_valid,
  output logic [`AGU_TAG_W-1:0]  miss_tag,
  output logic                  fault_valid,
  output fault_t                fault
);

  logic                 miss;
  logic [1:0]           page_fault;
  logic                 take_fault;
  logic                 take_miss;
  logic                 take_mop;
  logic                 live;
  mem_op_t              mop_d;
  fault_t               fault_d;
  logic                 mop_valid_q;
  logic                 miss_valid_q;
  logic                 fault_valid_q;

  always_comb begin
    // next page only matters when the store crosses into it
    miss       = ~s1_look.hit | (s1_cross_page & ~s1_look_next.hit);
    page_fault = s1_look.fault | (s1_cross_page ? s1_look_next.fault : 2'b00);

    // illegal opcode first, then miss, then page faults
    take_fault = s1_illegal | (~miss & (page_fault != 2'b00));
    take_miss  = ~s1_illegal & miss;
    take_mop   = ~take_fault & ~take_miss;

    fault_d.code = s1_illegal ? 3'b100 : {1'b0, page_fault};
    fault_d.tag  = s1_req.tag;

    mop_d.paddr      = {s1_look.ppn, s1_req.vaddr[`AGU_PAGE_W-1:0]};
    mop_d.paddr_next = s1_look_next.ppn;
    mop_d.banks      = s1_banks;
    mop_d.first_bank = s1_first_bank;
    mop_d.size       = s1_bytes;
    mop_d.split      = s1_split;
    mop_d.cross_page = s1_cross_page;
    mop_d.tag        = s1_req.tag;
  end

  assign live = s1_valid & ~cancel;

  always_ff @(posedge clk) begin
    if (rst) begin
      mop_valid_q   <= 1'b0;
      miss_valid_q  <= 1'b0;
      fault_valid_q <= 1'b0;
    end else begin
      mop_valid_q   <= live & take_mop;
      miss_valid_q  <= live & take_miss;
      fault_valid_q <= live & take_fault;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      mop      <= mop_d;
      fault    <= fault_d;
      miss_tag <= s1_req.tag;
    end
  end

  // cancel also kills whatever is leaving stage 2 this cycle
  assign mop_valid   = mop_valid_q & ~cancel;
  assign miss_valid  = miss_valid_q & ~cancel;
  assign fault_valid = fault_valid_q & ~cancel;

endmodule

/* source/store_agu.sv */
`timescale 1ns/1ps
`include "agu_settings.svh"

module store_agu import agu_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req_valid,
  input  agu_req_t                     req,
  input  logic                         cancel,
  input  logic                         tlb_wr,
  input  logic [$clog2(`AGU_TLB_ENTRIES)-1:0] tlb_wr_index,
  input  tlb_entry_t                   tlb_wr_entry,
  output logic                         mop_valid,
  output mem_op_t                      mop,
  output logic                         miss_valid,
  output logic [`AGU_TAG_W-1:0]         miss_tag,
  output logic                         fault_valid,
  output fault_t                       fault
);

  // stage 0, combinational
  logic [4:0]            bytes;
  logic                  illegal;
  logic [`AGU_BANKS-1:0]  banks;
  logic [BANK_W-1:0]     first_bank;
  logic                  split;
  logic                  cross_page;
  tlb_look_t             look;
  tlb_look_t             look_next;

  // stage 1 register
  logic                  s1_valid;
  agu_req_t              s1_req;
  logic [4:0]            s1_bytes;
  logic                  s1_illegal;
  logic [`AGU_BANKS-1:0]  s1_banks;
  logic [BANK_W-1:0]     s1_first_bank;
  logic                  s1_split;
  logic                  s1_cross_page;
  tlb_look_t             s1_look;
  tlb_look_t             s1_look_next;

  agu_op_decode i_op_decode (
    .op      (req.op),
    .bytes   (bytes),
    .illegal (illegal)
  );

  agu_bank_map i_bank_map (
    .vaddr_low  (req.vaddr[`AGU_PAGE_W-1:0]),
    .bytes      (bytes),
    .banks      (banks),
    .first_bank (first_bank),
    .split      (split),
    .cross_page (cross_page)
  );

  agu_dtlb i_dtlb (
    .clk       (clk),
    .rst       (rst),
    .wr        (tlb_wr),
    .wr_index  (tlb_wr_index),
    .wr_entry  (tlb_wr_entry),
    .vpn       (req.vaddr[`AGU_VADDR_W-1:`AGU_PAGE_W]),
    .kernel    (req.kernel),
    .look      (look),
    .look_next (look_next)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid & ~cancel;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      s1_req        <= req;
      s1_bytes      <= bytes;
      s1_illegal    <= illegal;
      s1_banks      <= banks;
      s1_first_bank <= first_bank;
      s1_split      <= split;
      s1_cross_page <= cross_page;
      s1_look       <= look;
      s1_look_next  <= look_next;
    end
  end

  agu_result i_result (
    .clk           (clk),
    .rst           (rst),
    .cancel        (cancel),
    .s1_valid      (s1_valid),
    .s1_req        (s1_req),
    .s1_illegal    (s1_illegal),
    .s1_bytes      (s1_bytes),
    .s1_banks      (s1_banks),
    .s1_first_bank (s1_first_bank),
    .s1_split      (s1_split),
    .s1_cross_page (s1_cross_page),
    .s1_look       (s1_look),
    .s1_look_next  (s1_look_next),
    .mop_valid     (mop_valid),
    .mop           (mop),
    .miss_valid    (miss_valid),
    .miss_tag      (miss_tag),
    .fault_valid   (fault_valid),
    .fault         (fault)
  );

endmodule

/* verif/store_agu_sva.sv */
`timescale 1ns/1ps

module store_agu_sva (
  input logic clk,
  input logic rst,
  input logic s1_valid,
  input logic mop_valid,
  input logic miss_valid,
  input logic fault_valid
);

  int unsigned fail_count = 0;
  logic        any_out;

  assign any_out = mop_valid | miss_valid | fault_valid;

  // one outcome per cycle at most
  a_one_outcome: assert property (@(posedge clk) disable iff (rst)
    $onehot0({mop_valid, miss_valid, fault_valid}))
    else begin
      fail_count++;
      $error("more than one outcome strobe in a cycle");
    end

  // pipeline empty right after a reset edge
  a_reset_quiet: assert property (@(posedge clk) rst |=> !(any_out || s1_valid))
    else begin
      fail_count++;
      $error("strobe or stage valid high after reset");
    end

  a_from_stage1: assert property (@(posedge clk) disable iff (rst) any_out |-> $past(s1_valid))
    else begin
      fail_count++;
      $error("outcome without a stage-1 entry the cycle before");
    end

endmodule

bind store_agu store_agu_sva i_sva (
  .clk         (clk),
  .rst         (rst),
  .s1_valid    (s1_valid),
  .mop_valid   (mop_valid),
  .miss_valid  (miss_valid),
  .fault_valid (fault_valid)
);

/* verif/store_agu_tb.sv */
`timescale 1ns/1ps
`include "agu_settings.svh"

module store_agu_tb import agu_pkg::*; ();

  typedef enum {k_mop, k_miss, k_fault} kind_e;

  typedef struct {
    string                   name;
    store_op_e               op;
    logic [`AGU_VADDR_W-1:0] vaddr;
    logic                    kernel;
    logic                    cancel;
    logic                    tlb_first;
    kind_e                   kind;
    logic [2:0]              code;
  } row_t;

  typedef struct {
    string                 name;
    kind_e                 kind;
    int                    due;
    mem_op_t               mop;
    logic [`AGU_TAG_W-1:0] tag;
    fault_t                fault;
  } exp_t;

  logic                  clk;
  logic                  rst;
  logic                  req_valid;
  agu_req_t              req;
  logic                  cancel;
  logic                  tlb_wr;
  logic [2:0]            tlb_wr_index;
  tlb_entry_t            tlb_wr_entry;
  logic                  mop_valid;
  mem_op_t               mop;
  logic                  miss_valid;
  logic [`AGU_TAG_W-1:0] miss_tag;
  logic                  fault_valid;
  fault_t                fault;

  row_t                         rows[$];
  exp_t                         expq[$];
  // model of the TLB contents
  tlb_entry_t                   img[`AGU_TLB_ENTRIES];
  logic [`AGU_TLB_ENTRIES-1:0]  img_valid = '0;
  logic [31:0]                  lfsr = 32'h483e;
  int                           cyc = 0;

  store_agu i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
  end

  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic int random_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_bit());
    end
    return v;
  endfunction

  function automatic int size_of(store_op_e op);
    case (op)
      op_st_b: return 1;
      op_st_h: return 2;
      op_st_w: return 4;
      op_st_d: return 8;
      op_st_q: return 16;
      default: return 1;
    endcase
  endfunction

  function automatic logic [PPN_W-1:0] ppn_of(logic [VPN_W-1:0] vpn);
    logic [PPN_W-1:0] ppn;
    ppn = '0;
    for (int i = 0; i < `AGU_TLB_ENTRIES; i++) begin
      if (img_valid[i] && img[i].vpn == vpn) begin
        ppn = img[i].ppn;
      end
    end
    return ppn;
  endfunction

  // reference model for one accepted request
  function automatic exp_t expect_for(row_t r, logic [`AGU_TAG_W-1:0] tag, int due);
    exp_t             e;
    int               bytes;
    int               first;
    int               count;
    int               off;
    logic [VPN_W-1:0] vpn;
    bytes = size_of(r.op);
    off   = int'(r.vaddr[`AGU_PAGE_W-1:0]);
    vpn   = r.vaddr[`AGU_VADDR_W-1:`AGU_PAGE_W];
    first = int'(r.vaddr[6:2]);
    count = (int'(r.vaddr[1:0]) + bytes + 3) / 4;
    e.name        = r.name;
    e.kind        = r.kind;
    e.due         = due;
    e.tag         = tag;
    e.fault.code  = r.code;
    e.fault.tag   = tag;
    e.mop         = '0;
    for (int i = 0; i < count; i++) begin
      e.mop.banks[(first + i) % `AGU_BANKS] = 1'b1;
    end
    e.mop.paddr      = {ppn_of(vpn), r.vaddr[`AGU_PAGE_W-1:0]};
    e.mop.paddr_next = ppn_of(vpn + 1'b1);
    e.mop.first_bank = BANK_W'(first);
    e.mop.size       = 5'(bytes);
    e.mop.split      = (first + count) > `AGU_BANKS;
    e.mop.cross_page = (off + bytes) > (1 << `AGU_PAGE_W);
    e.mop.tag        = tag;
    return e;
  endfunction

  function automatic tlb_entry_t make_entry(int vpn, int ppn, logic p, logic wp, logic sys);
    return '{VPN_W'(vpn), PPN_W'(ppn), p, wp, sys};
  endfunction

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_kind(string name, kind_e exp, kind_e act);
    if (exp != act) begin
      stop_run($sformatf("Mismatch %s: expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_mop(string name, mem_op_t exp, mem_op_t act);
    if (exp !== act) begin
      stop_run($sformatf("Mismatch %s: expected mop %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_miss(string name, logic [`AGU_TAG_W-1:0] exp, logic [`AGU_TAG_W-1:0] act);
    if (exp !== act) begin
      stop_run($sformatf("Mismatch %s: expected miss tag %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_fault(string name, fault_t exp, fault_t act);
    if (exp !== act) begin
      stop_run($sformatf("Mismatch %s: expected fault %h actual %h", name, exp, act));
    end
  endtask

  // outputs sampled mid-cycle, away from both edges
  task automatic check_outputs();
    exp_t  e;
    kind_e got;
    int    n;
    n = int'(mop_valid) + int'(miss_valid) + int'(fault_valid);
    if (i_dut.i_sva.fail_count != 0) begin
      stop_run("an assertion in store_agu_sva failed");
    end else if (expq.size() > 0 && expq[0].due == cyc) begin
      e = expq.pop_front();
      if (n != 1) begin
        stop_run($sformatf("%s should give one outcome strobe but gave %0d", e.name, n));
      end else begin
        got = mop_valid ? k_mop : (miss_valid ? k_miss : k_fault);
        check_kind(e.name, e.kind, got);
        case (got)
          k_mop:   check_mop(e.name, e.mop, mop);
          k_miss:  check_miss(e.name, e.tag, miss_tag);
          default: check_fault(e.name, e.fault, fault);
        endcase
      end
    end else if (n != 0) begin
      stop_run("an outcome strobe appeared with no request due");
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      check_outputs();
    end
  end

  task automatic write_tlb(int idx, tlb_entry_t entry);
    req_valid    = 1'b0;
    tlb_wr       = 1'b1;
    tlb_wr_index = 3'(idx);
    tlb_wr_entry = entry;
    img[idx]       = entry;
    img_valid[idx] = 1'b1;
    @(posedge clk);
    #1;
    tlb_wr = 1'b0;
  endtask

  task automatic add_row(string name, store_op_e op, int vpn, int off, kind_e kind,
                         logic [2:0] code = 3'b000, logic kernel = 1'b0,
                         logic cancel_req = 1'b0, logic tlb_first = 1'b0);
    row_t r;
    r.name      = name;
    r.op        = op;
    r.vaddr     = {VPN_W'(vpn), `AGU_PAGE_W'(off)};
    r.kernel    = kernel;
    r.cancel    = cancel_req;
    r.tlb_first = tlb_first;
    r.kind      = kind;
    r.code      = code;
    rows.push_back(r);
  endtask

  task automatic build_table();
    for (int o = 0; o < 5; o++) begin
      for (int f = 0; f < 4; f++) begin
        add_row($sformatf("size_op%0d_off%0d", o, f), store_op_e'(o), 'h10, 'h40 + f, k_mop);
      end
    end
    add_row("wrap_d_bank30", op_st_d, 'h10, 'h078, k_mop);
    add_row("wrap_d_bank31", op_st_d, 'h10, 'h07c, k_mop);
    add_row("wrap_h_inside", op_st_h, 'h10, 'h07e, k_mop);
    add_row("wrap_h_split", op_st_h, 'h10, 'h07f, k_mop);
    add_row("wrap_q_bank28", op_st_q, 'h10, 'h070, k_mop);
    add_row("wrap_q_split", op_st_q, 'h10, 'h071, k_mop);
    add_row("cross_q", op_st_q, 'h10, 'h1ff8, k_mop);
    add_row("cross_w", op_st_w, 'h11, 'h1ffd, k_mop);
    add_row("page_end_b", op_st_b, 'h11, 'h1fff, k_mop);
    add_row("hit_other", op_st_d, 'h40, 'h100, k_mop);
    add_row("miss_page", op_st_w, 'h70, 'h0, k_miss);
    add_row("miss_next", op_st_d, 'h40, 'h1ffc, k_miss);
    add_row("write_protect", op_st_w, 'h20, 'h8, k_fault, 3'b001);
    add_row("not_present", op_st_b, 'h50, 'h3, k_fault, 3'b001);
    add_row("system_user", op_st_h, 'h30, 'h2, k_fault, 3'b010);
    add_row("system_kernel", op_st_h, 'h30, 'h2, k_mop, 3'b000, 1'b1);
    add_row("illegal_op", store_op_e'(3'd5), 'h10, 'h0, k_fault, 3'b100);
    add_row("illegal_on_miss", store_op_e'(3'd7), 'h70, 'h0, k_fault, 3'b100);
    // first three die with the cancel, the fourth survives
    add_row("killed_a", op_st_w, 'h10, 'h20, k_mop);
    add_row("killed_b", op_st_w, 'h11, 'h24, k_mop);
    add_row("cancel", op_st_w, 'h10, 'h28, k_mop, 3'b000, 1'b0, 1'b1);
    add_row("after_cancel", op_st_w, 'h10, 'h2c, k_mop);
    add_row("late_before", op_st_w, 'h60, 'h0, k_miss);
    add_row("late_after", op_st_w, 'h60, 'h10, k_mop, 3'b000, 1'b0, 1'b0, 1'b1);
    // random stores inside the two pages with a present successor
    for (int i = 0; i < 12; i++) begin
      add_row($sformatf("random_%0d", i), store_op_e'(3'(random_bits(3) % 5)),
              'h10 + random_bits(1), random_bits(13), k_mop, 3'b000, 1'(random_bits(1)));
    end
  endtask

  task automatic apply_row(row_t r, logic [`AGU_TAG_W-1:0] tag);
    if (r.tlb_first) begin
      write_tlb(7, make_entry('h60, 'h1234, 1'b1, 1'b0, 1'b0));
    end
    req_valid = 1'b1;
    req       = '{r.op, r.vaddr, r.kernel, tag};
    cancel    = r.cancel;
    if (r.cancel) begin
      expq.delete();
    end else begin
      expq.push_back(expect_for(r, tag, cyc + 2));
    end
    @(posedge clk);
    #1;
    cancel = 1'b0;
  endtask

  initial begin
    int wait_cycles;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    cancel       = 1'b0;
    tlb_wr       = 1'b0;
    tlb_wr_index = '0;
    tlb_wr_entry = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    write_tlb(0, make_entry('h10, 'h100, 1'b1, 1'b0, 1'b0));
    write_tlb(1, make_entry('h11, 'h2a5, 1'b1, 1'b0, 1'b0));
    write_tlb(2, make_entry('h20, 'h300, 1'b1, 1'b1, 1'b0));
    write_tlb(3, make_entry('h30, 'h400, 1'b1, 1'b0, 1'b1));
    write_tlb(4, make_entry('h40, 'h500, 1'b1, 1'b0, 1'b0));
    write_tlb(5, make_entry('h50, 'h600, 1'b0, 1'b0, 1'b0));
    write_tlb(6, make_entry('h12, 'h7777, 1'b1, 1'b0, 1'b0));

    build_table();
    foreach (rows[i]) begin
      apply_row(rows[i], `AGU_TAG_W'(i));
    end
    req_valid = 1'b0;

    wait_cycles = 0;
    while (expq.size() > 0 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    // idle cycles catch stray strobes
    repeat (4) @(posedge clk);
    if (expq.size() > 0) begin
      stop_run("timed out waiting for the last outcomes");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* list.f */
+incdir+source
source/agu_pkg.sv
source/agu_op_decode.sv
source/agu_bank_map.sv
source/agu_dtlb.sv
source/agu_result.sv
source/store_agu.sv
verif/store_agu_sva.sv
verif/store_agu_tb.sv

/* Bender.yml */
package:
  name: store_agu

export_include_dirs:
  - source

sources:
  - files:
      - source/agu_pkg.sv
      - source/agu_op_decode.sv
      - source/agu_bank_map.sv
      - source/agu_dtlb.sv
      - source/agu_result.sv
      - source/store_agu.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/store_agu_sva.sv
      - verif/store_agu_tb.sv
